//--- Makefile
# verilator build and run for the dma copy engine testbench

SIM      = verilator
FLAGS    = --binary --assert --timing --timescale 1ns/1ps
TOP      = dma_tb
FILELIST = compile.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = All tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, then check the log"
	@echo "  clean  remove the build output and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- compile.f
+incdir+include
verilog/dma_pkg.sv
verilog/dma_scratch_mem.sv
verilog/dma_addr_gen.sv
verilog/dma_byte_mover.sv
verilog/dma_apb_regs.sv
verilog/dma_top.sv
test/dma_chk.sv
test/dma_tb.sv

//--- include/dma_settings.svh
// dma copy engine settings
// widths, memory depth and the apb register map
`ifndef DMA_SETTINGS_SVH
`define DMA_SETTINGS_SVH

// memory word and byte lanes
`define DMA_DATA_W          32
`define DMA_BYTES_PER_WORD  4
`define DMA_MEM_WORDS       64

// byte address into scratch memory, wraps at 256
`define DMA_ADDR_W          8

// apb side
`define DMA_APB_ADDR_W      12
`define DMA_REG_SRC         12'h000
`define DMA_REG_DST         12'h004
`define DMA_REG_LEN         12'h008
`define DMA_REG_CTRL        12'h00C
// 256 byte memory window, word aligned
`define DMA_MEM_BASE        12'h400

`endif

//--- test/dma_chk.sv
// dma copy engine protocol checks
// apb ready and busy rules, bound into the top level
`timescale 1ns/1ps
`include "dma_settings.svh"

module dma_chk (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        psel_i,
    input  logic                        penable_i,
    input  logic                        pwrite_i,
    input  logic [`DMA_APB_ADDR_W-1:0]  paddr_i,
    input  logic [`DMA_DATA_W-1:0]      pwdata_i,
    input  logic                        pready_i,
    input  logic                        busy_i,
    input  logic                        start_i,
    input  logic                        done_i
);

    logic start_wr;

    // ctrl write with bit 0 set, access phase
    assign start_wr = psel_i & penable_i & pwrite_i & pwdata_i[0] &
                      (paddr_i == `DMA_REG_CTRL);

    // ----------------------------------------------------------------------
    // apb handshake
    // ----------------------------------------------------------------------

    // ready only inside an access phase
    ready_in_access: assert property (
        @(posedge clk) disable iff (reset_i)
        pready_i |-> (psel_i && penable_i)
    ) else $error("pready high outside an apb access phase");

    // ----------------------------------------------------------------------
    // busy
    // ----------------------------------------------------------------------

    // every reset cycle leaves busy low
    busy_low_in_reset: assert property (
        @(posedge clk)
        reset_i |=> !busy_i
    ) else $error("busy high after a reset cycle");

    // second start is dropped, busy holds unless done ends the copy
    start_ignored_when_busy: assert property (
        @(posedge clk) disable iff (reset_i)
        (start_wr && busy_i && !done_i) |=> (busy_i && !start_i)
    ) else $error("start write while busy changed the engine state");

endmodule

bind dma_top dma_chk u_chk (
    .clk       (clk),
    .reset_i   (reset_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .pready_i  (pready_o),
    .busy_i    (busy_o),
    .start_i   (start),
    .done_i    (done)
);

//--- test/dma_tb.sv
// dma copy engine testbench
// apb driven copies checked against a byte level reference model
`timescale 1ns/1ps
`include "dma_settings.svh"

module dma_tb;

    localparam int APB_TIMEOUT  = 200;
    localparam int IDLE_TIMEOUT = 1000;
    localparam int CMP_TIMEOUT  = 4000;
    localparam logic [`DMA_APB_ADDR_W-1:0] MEM_BASE = `DMA_MEM_BASE;

    logic                       clk;
    logic                       reset_i;
    logic                       psel_i;
    logic                       penable_i;
    logic                       pwrite_i;
    logic [`DMA_APB_ADDR_W-1:0] paddr_i;
    logic [`DMA_DATA_W-1:0]     pwdata_i;
    logic [`DMA_DATA_W-1:0]     prdata_o;
    logic                       pready_o;
    logic                       pslverr_o;
    logic                       busy_o;

    // byte image of the scratch memory
    logic [7:0]  ref_mem [256];
    logic [31:0] lfsr_q;
    int          cycle_cnt = 0;
    int          checks = 0;
    int          errors = 0;
    // handshake with the compare process
    logic        cmp_req = 1'b0;
    string       cmp_name;
    // raised by a wait that ran out of time
    logic        abort_req = 1'b0;

    dma_top dut (
        .clk       (clk),
        .reset_i   (reset_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .busy_o    (busy_o)
    );

    // 40 ns clock
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // a timed out wait ends the run at the next rising edge
    always @(posedge clk) begin
        if (abort_req) begin
            $display("checks: %0d, errors: %0d", checks, errors);
            $display("Some tests failed");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------

    // fibonacci lfsr on taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic logic [11:0] win_addr(input logic [5:0] w);
        return MEM_BASE + {4'd0, w, 2'b00};
    endfunction

    // lane b of a word holds byte address {w, b}
    function automatic logic [31:0] ref_word(input logic [5:0] w);
        return {ref_mem[{w, 2'd3}], ref_mem[{w, 2'd2}],
                ref_mem[{w, 2'd1}], ref_mem[{w, 2'd0}]};
    endfunction

    function automatic void set_ref_word(input logic [5:0] w, input logic [31:0] data);
        for (int b = 0; b < 4; b++) begin
            ref_mem[{w, 2'(b)}] = data[8*b +: 8];
        end
    endfunction

    // byte i of src goes to byte i of dst with addresses wrapping at 256
    function automatic void ref_copy(input logic [7:0] src, input logic [7:0] dst,
                                     input int len);
        logic [7:0] s;
        logic [7:0] d;
        s = src;
        d = dst;
        for (int i = 0; i < len; i++) begin
            ref_mem[d] = ref_mem[s];
            s = s + 8'd1;
            d = d + 8'd1;
        end
    endfunction

    // count the timeout and stall this process until the monitor ends the run
    task automatic abort_run(input string why);
        $display("%s", why);
        errors++;
        abort_req = 1'b1;
        forever @(posedge clk);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: expected %08h, actual %08h", name, expected, actual);
        end
    endtask

    // ----------------------------------------------------------------------
    // apb master
    // ----------------------------------------------------------------------

    // setup, access, then hold until pready seen at a falling edge
    task automatic apb_access(input logic wr, input logic [11:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        int waited;
        @(posedge clk);
        #2;
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = wr;
        paddr_i   = addr;
        pwdata_i  = wdata;
        @(posedge clk);
        #2;
        penable_i = 1'b1;
        waited = 0;
        @(negedge clk);
        while (!pready_o && waited < APB_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!pready_o) begin
            abort_run($sformatf("apb access to %03h got no pready", addr));
        end else begin
            rdata = prdata_o;
            err   = pslverr_o;
            @(posedge clk);
            #2;
            psel_i    = 1'b0;
            penable_i = 1'b0;
            pwrite_i  = 1'b0;
        end
    endtask

    task automatic reg_write(input logic [11:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, addr, data, rdata, err);
        check_value($sformatf("pslverr on write %03h", addr), 32'd0, 32'(err));
    endtask

    task automatic reg_read(input logic [11:0] addr, output logic [31:0] data);
        logic err;
        apb_access(1'b0, addr, 32'd0, data, err);
        check_value($sformatf("pslverr on read %03h", addr), 32'd0, 32'(err));
    endtask

    // program the registers, start, and update the model
    task automatic start_copy(input logic [7:0] src, input logic [7:0] dst, input int len,
                              output int start_cycle);
        reg_write(`DMA_REG_SRC, {24'd0, src});
        reg_write(`DMA_REG_DST, {24'd0, dst});
        reg_write(`DMA_REG_LEN, 32'(len));
        reg_write(`DMA_REG_CTRL, 32'd1);
        start_cycle = cycle_cnt;
        ref_copy(src, dst, len);
    endtask

    task automatic wait_idle(output int fall_cycle);
        int waited;
        waited = 0;
        @(negedge clk);
        while (busy_o && waited < IDLE_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (busy_o) abort_run("copy engine stayed busy past the timeout");
        fall_cycle = cycle_cnt;
    endtask

    // hand the readback to the compare process and wait for it
    task automatic compare_memory(input string name);
        int waited;
        cmp_name = name;
        cmp_req  = 1'b1;
        waited   = 0;
        while (cmp_req && waited < CMP_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (cmp_req) abort_run($sformatf("memory readback for %s did not finish", name));
    endtask

    // ----------------------------------------------------------------------
    // compare process reads every window word against the model
    // ----------------------------------------------------------------------

    initial begin
        logic [31:0] data;
        forever begin
            @(posedge clk);
            if (cmp_req) begin
                for (int w = 0; w < `DMA_MEM_WORDS; w++) begin
                    reg_read(win_addr(6'(w)), data);
                    check_value($sformatf("%s word %0d", cmp_name, w),
                                ref_word(6'(w)), data);
                end
                cmp_req = 1'b0;
            end
        end
    end

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------

    initial begin
        int          start_cycle;
        int          fall_cycle;
        int          len;
        logic [7:0]  src;
        logic [7:0]  dst;
        logic [31:0] rdata;
        logic        err;

        lfsr_q    = 32'h4266fef9;
        reset_i   = 1'b1;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = '0;
        pwdata_i  = '0;
        repeat (10) @(posedge clk);
        #2;
        reset_i = 1'b0;

        // window write then read back
        for (int w = 0; w < `DMA_MEM_WORDS; w++) begin
            rdata = rand_bits(32);
            reg_write(win_addr(6'(w)), rdata);
            set_ref_word(6'(w), rdata);
        end
        compare_memory("window_rw");

        // word aligned copy with dst half a memory away
        len = 1 + int'(rand_bits(6));
        src = 8'(rand_bits(6) << 2);
        dst = src + 8'd128;
        start_copy(src, dst, len, start_cycle);
        wait_idle(fall_cycle);
        compare_memory("aligned_copy");

        // lanes differ by one or two
        len = 1 + int'(rand_bits(6));
        src = 8'(rand_bits(8));
        dst = src + 8'd129 + 8'(rand_bits(1));
        start_copy(src, dst, len, start_cycle);
        wait_idle(fall_cycle);
        compare_memory("misaligned_copy");

        // busy status, fall time and a dropped second start
        len = 12 + int'(rand_bits(4));
        start_copy(8'h10, 8'h90, len, start_cycle);
        reg_read(`DMA_REG_CTRL, rdata);
        check_value("busy_after_start", 32'd1, rdata);
        reg_write(`DMA_REG_CTRL, 32'd1);
        wait_idle(fall_cycle);
        check_value("busy_fall_cycles", 32'(len + 3), 32'(fall_cycle - start_cycle));
        reg_read(`DMA_REG_CTRL, rdata);
        check_value("idle_after_copy", 32'd0, rdata);
        compare_memory("busy_copy");

        // unmapped addresses
        apb_access(1'b0, 12'h100, 32'd0, rdata, err);
        check_value("bad_addr_read_pslverr", 32'd1, 32'(err));
        apb_access(1'b1, 12'h010, 32'hdeadbeef, rdata, err);
        check_value("bad_addr_write_pslverr", 32'd1, 32'(err));

        // window write held until one cycle after busy falls
        len = 16 + int'(rand_bits(4));
        start_copy(8'h00, 8'h40, len, start_cycle);
        rdata = rand_bits(32);
        reg_write(win_addr(6'h30), rdata);
        check_value("busy_write_done_cycle", 32'(len + 4), 32'(cycle_cnt - start_cycle));
        set_ref_word(6'h30, rdata);

        // window read needs the extra memory cycle
        len = 16 + int'(rand_bits(4));
        start_copy(8'h80, 8'h20, len, start_cycle);
        reg_read(win_addr(6'h30), rdata);
        check_value("busy_read_done_cycle", 32'(len + 5), 32'(cycle_cnt - start_cycle));
        check_value("busy_read_data", ref_word(6'h30), rdata);
        wait_idle(fall_cycle);
        compare_memory("busy_window");

        // source wraps past 255
        len = 33 + int'(rand_bits(5));
        src = 8'hE0 + 8'(rand_bits(4));
        dst = src + 8'd130;
        start_copy(src, dst, len, start_cycle);
        wait_idle(fall_cycle);
        // destination wraps past 255
        len = 33 + int'(rand_bits(5));
        src = 8'h40 + 8'(rand_bits(4));
        dst = src + 8'hA0;
        start_copy(src, dst, len, start_cycle);
        wait_idle(fall_cycle);
        compare_memory("wrap_copy");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- verilog/dma_addr_gen.sv
// dma address generator, first pipeline stage
// walks src and dst one byte per cycle for len bytes
`timescale 1ns/1ps
`include "dma_settings.svh"

module dma_addr_gen (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    start_i,
    input  dma_pkg::byte_addr_t     src_i,
    input  dma_pkg::byte_addr_t     dst_i,
    input  logic [`DMA_ADDR_W:0]    len_i,
    output logic                    rd_en_o,
    output dma_pkg::word_addr_t     rd_word_o,
    output dma_pkg::lane_t          src_lane_o,
    output dma_pkg::byte_addr_t     dst_addr_o,
    output logic                    last_o
);
    import dma_pkg::*;

    localparam int LANE_W = $clog2(`DMA_BYTES_PER_WORD);

    logic                   active_q;
    logic [`DMA_ADDR_W:0]   remain_q;
    byte_addr_t             src_q;
    byte_addr_t             dst_q;

    // ----------------------------------------------------------------------
    // byte counter
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset_i) begin
            active_q <= 1'b0;
            remain_q <= '0;
        end else if (start_i) begin
            active_q <= 1'b1;
            remain_q <= len_i;
        end else if (active_q) begin
            remain_q <= remain_q - 1'b1;
            // final byte goes out this cycle
            if (remain_q == 1) active_q <= 1'b0;
        end
    end

    // current addresses, 8 bit add wraps at 256
    always_ff @(posedge clk) begin
        if (start_i) begin
            src_q <= src_i;
            dst_q <= dst_i;
        end else if (active_q) begin
            src_q <= src_q + 1'b1;
            dst_q <= dst_q + 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // outputs to memory read port and mover
    // ----------------------------------------------------------------------

    assign rd_en_o    = active_q;
    assign rd_word_o  = src_q[`DMA_ADDR_W-1:LANE_W];
    assign src_lane_o = src_q[LANE_W-1:0];
    assign dst_addr_o = dst_q;
    assign last_o     = active_q & (remain_q == 1);

endmodule

//--- verilog/dma_apb_regs.sv
// dma apb slave with src, dst, len and ctrl registers
// tracks busy and gates the memory window while a copy runs
`timescale 1ns/1ps
`include "dma_settings.svh"

module dma_apb_regs (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        psel_i,
    input  logic                        penable_i,
    input  logic                        pwrite_i,
    input  logic [`DMA_APB_ADDR_W-1:0]  paddr_i,
    input  logic [`DMA_DATA_W-1:0]      pwdata_i,
    output logic [`DMA_DATA_W-1:0]      prdata_o,
    output logic                        pready_o,
    output logic                        pslverr_o,
    output logic                        start_o,
    output dma_pkg::byte_addr_t         src_o,
    output dma_pkg::byte_addr_t         dst_o,
    output logic [`DMA_ADDR_W:0]        len_o,
    input  logic                        done_i,
    output logic                        busy_o,
    output logic                        win_rd_en_o,
    output logic                        win_wr_en_o,
    output dma_pkg::word_addr_t         win_word_o,
    output dma_pkg::mem_word_t          win_wdata_o,
    input  dma_pkg::mem_word_t          win_rdata_i
);
    import dma_pkg::*;

    localparam int LANE_W = $clog2(`DMA_BYTES_PER_WORD);
    localparam logic [`DMA_APB_ADDR_W-1:0] MEM_BASE = `DMA_MEM_BASE;

    byte_addr_t                 src_q;
    byte_addr_t                 dst_q;
    logic [`DMA_ADDR_W:0]       len_q;
    logic                       busy_q;
    logic                       start_q;
    logic                       rd_wait_q;
    logic                       access;
    logic                       hit_src, hit_dst, hit_len, hit_ctrl;
    logic                       hit_win;
    logic                       start_req;

    // ----------------------------------------------------------------------
    // address decode
    // ----------------------------------------------------------------------

    // access phase of an apb transfer
    assign access   = psel_i & penable_i;
    assign hit_src  = (paddr_i == `DMA_REG_SRC);
    assign hit_dst  = (paddr_i == `DMA_REG_DST);
    assign hit_len  = (paddr_i == `DMA_REG_LEN);
    assign hit_ctrl = (paddr_i == `DMA_REG_CTRL);
    // window covers base .. base+255, low two bits ignored
    assign hit_win  = (paddr_i[`DMA_APB_ADDR_W-1:`DMA_ADDR_W] ==
                       MEM_BASE[`DMA_APB_ADDR_W-1:`DMA_ADDR_W]);

    // start only from idle with a non-zero length
    assign start_req = access & pwrite_i & hit_ctrl & pwdata_i[0] &
                       ~busy_q & (len_q != '0);

    // ----------------------------------------------------------------------
    // registers
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset_i) begin
            src_q <= '0;
            dst_q <= '0;
            len_q <= '0;
        end else if (access && pwrite_i) begin
            // register writes complete in the first access cycle
            if (hit_src) src_q <= pwdata_i[`DMA_ADDR_W-1:0];
            if (hit_dst) dst_q <= pwdata_i[`DMA_ADDR_W-1:0];
            if (hit_len) len_q <= pwdata_i[`DMA_ADDR_W:0];
        end
    end

    // busy rises with the start write, falls on done from the mover
    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_q    <= 1'b0;
            start_q   <= 1'b0;
            rd_wait_q <= 1'b0;
        end else begin
            start_q   <= start_req;
            rd_wait_q <= win_rd_en_o;
            if (start_req) begin
                busy_q <= 1'b1;
            end else if (done_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    // ----------------------------------------------------------------------
    // memory window
    // ----------------------------------------------------------------------

    // window waits while the pipeline owns the memory
    assign win_wr_en_o = access & hit_win & pwrite_i & ~busy_q;
    // issue the read once, data comes back next cycle
    assign win_rd_en_o = access & hit_win & ~pwrite_i & ~busy_q & ~rd_wait_q;
    assign win_word_o  = paddr_i[`DMA_ADDR_W-1:LANE_W];

    always_comb begin
        win_wdata_o.data = pwdata_i;
    end

    // ----------------------------------------------------------------------
    // apb response
    // ----------------------------------------------------------------------

    always_comb begin
        pready_o = 1'b0;
        if (access) begin
            if (hit_win) begin
                pready_o = pwrite_i ? ~busy_q : rd_wait_q;
            end else begin
                // registers and decode errors finish at once
                pready_o = 1'b1;
            end
        end
    end

    assign pslverr_o = access & ~(hit_src | hit_dst | hit_len | hit_ctrl | hit_win);

    always_comb begin
        prdata_o = '0;
        if (hit_src)  prdata_o[`DMA_ADDR_W-1:0] = src_q;
        if (hit_dst)  prdata_o[`DMA_ADDR_W-1:0] = dst_q;
        if (hit_len)  prdata_o[`DMA_ADDR_W:0]   = len_q;
        if (hit_ctrl) prdata_o[0]               = busy_q;
        if (hit_win)  prdata_o                  = win_rdata_i.data;
    end

    assign start_o = start_q;
    assign src_o   = src_q;
    assign dst_o   = dst_q;
    assign len_o   = len_q;
    assign busy_o  = busy_q;

endmodule

//--- verilog/dma_byte_mover.sv
// dma byte mover, third pipeline stage
// lifts the source lane out of the read word and writes it to the dst lane
`timescale 1ns/1ps
`include "dma_settings.svh"

module dma_byte_mover (
    input  logic                            clk,
    input  logic                            reset_i,
    input  logic                            valid_i,
    input  dma_pkg::lane_t                  src_lane_i,
    input  dma_pkg::byte_addr_t             dst_addr_i,
    input  logic                            last_i,
    input  dma_pkg::mem_word_t              rd_data_i,
    output logic                            wr_en_o,
    output dma_pkg::word_addr_t             wr_word_o,
    output logic [`DMA_BYTES_PER_WORD-1:0]  wr_strb_o,
    output dma_pkg::mem_word_t              wr_data_o,
    output logic                            done_o
);
    import dma_pkg::*;

    localparam int LANE_W = $clog2(`DMA_BYTES_PER_WORD);

    logic       valid_q;
    logic       last_q;
    logic       done_q;
    lane_t      lane_q;
    byte_addr_t dst_q;
    logic [7:0] src_byte;

    // ----------------------------------------------------------------------
    // stage register, lines up with the registered read data
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            valid_q <= valid_i;
            // pulse once the last byte is written
            done_q  <= valid_q & last_q;
        end
    end

    always_ff @(posedge clk) begin
        lane_q <= src_lane_i;
        dst_q  <= dst_addr_i;
        last_q <= last_i;
    end

    // ----------------------------------------------------------------------
    // realign and write
    // ----------------------------------------------------------------------

    assign src_byte = rd_data_i.bytes[lane_q];

    always_comb begin
        // byte copied to every lane, strobe picks one
        wr_data_o.bytes = {`DMA_BYTES_PER_WORD{src_byte}};
        wr_strb_o = '0;
        wr_strb_o[dst_q[LANE_W-1:0]] = 1'b1;
    end

    assign wr_en_o   = valid_q;
    assign wr_word_o = dst_q[`DMA_ADDR_W-1:LANE_W];
    assign done_o    = done_q;

endmodule

//--- verilog/dma_pkg.sv
// dma copy engine types
// address types and the two views of a memory word
`include "dma_settings.svh"

package dma_pkg;

    // ----------------------------------------------------------------------
    // addressing
    // ----------------------------------------------------------------------

    // byte address, split as {word, lane}
    typedef logic [`DMA_ADDR_W-1:0] byte_addr_t;

    // word index into the 64 deep memory
    typedef logic [$clog2(`DMA_MEM_WORDS)-1:0] word_addr_t;

    // byte offset inside one word
    typedef logic [$clog2(`DMA_BYTES_PER_WORD)-1:0] lane_t;

    // ----------------------------------------------------------------------
    // memory word
    // ----------------------------------------------------------------------

    // apb window sees whole words, the byte mover sees lanes
    typedef union packed {
        logic [`DMA_DATA_W-1:0]                data;
        logic [`DMA_BYTES_PER_WORD-1:0][7:0]   bytes;
    } mem_word_t;

endpackage

//--- verilog/dma_scratch_mem.sv
// scratch memory, 64 x 32 bit
// registered read port, byte strobed write port
`timescale 1ns/1ps
`include "dma_settings.svh"

module dma_scratch_mem (
    input  logic                            clk,
    input  logic                            rd_en_i,
    input  dma_pkg::word_addr_t             rd_word_i,
    output dma_pkg::mem_word_t              rd_data_o,
    input  logic                            wr_en_i,
    input  dma_pkg::word_addr_t             wr_word_i,
    input  logic [`DMA_BYTES_PER_WORD-1:0]  wr_strb_i,
    input  dma_pkg::mem_word_t              wr_data_i
);
    import dma_pkg::*;

    mem_word_t mem [`DMA_MEM_WORDS];
    mem_word_t rd_data_q;

    // read returns old contents on a same-word write
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_q <= mem[rd_word_i];
        end
    end

    // one enable per byte lane
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            for (int b = 0; b < `DMA_BYTES_PER_WORD; b++) begin
                if (wr_strb_i[b]) mem[wr_word_i].bytes[b] <= wr_data_i.bytes[b];
            end
        end
    end

    assign rd_data_o = rd_data_q;

endmodule

//--- verilog/dma_top.sv
// dma copy engine top level
// apb registers, three stage byte pipeline and scratch memory
`timescale 1ns/1ps
`include "dma_settings.svh"

module dma_top (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        psel_i,
    input  logic                        penable_i,
    input  logic                        pwrite_i,
    input  logic [`DMA_APB_ADDR_W-1:0]  paddr_i,
    input  logic [`DMA_DATA_W-1:0]      pwdata_i,
    output logic [`DMA_DATA_W-1:0]      prdata_o,
    output logic                        pready_o,
    output logic                        pslverr_o,
    output logic                        busy_o
);
    import dma_pkg::*;

    // register block to pipeline
    logic                           start;
    byte_addr_t                     cfg_src;
    byte_addr_t                     cfg_dst;
    logic [`DMA_ADDR_W:0]           cfg_len;
    logic                           done;
    logic                           busy;

    // window side
    logic                           win_rd_en;
    logic                           win_wr_en;
    word_addr_t                     win_word;
    mem_word_t                      win_wdata;

    // stage one outputs
    logic                           gen_rd_en;
    word_addr_t                     gen_rd_word;
    lane_t                          gen_lane;
    byte_addr_t                     gen_dst;
    logic                           gen_last;

    // stage three outputs
    logic                           mov_wr_en;
    word_addr_t                     mov_wr_word;
    logic [`DMA_BYTES_PER_WORD-1:0] mov_wr_strb;
    mem_word_t                      mov_wr_data;

    // memory ports
    logic                           mem_rd_en;
    word_addr_t                     mem_rd_word;
    mem_word_t                      mem_rd_data;
    logic                           mem_wr_en;
    word_addr_t                     mem_wr_word;
    logic [`DMA_BYTES_PER_WORD-1:0] mem_wr_strb;
    mem_word_t                      mem_wr_data;

    dma_apb_regs u_regs (
        .clk         (clk),
        .reset_i     (reset_i),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .paddr_i     (paddr_i),
        .pwdata_i    (pwdata_i),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .pslverr_o   (pslverr_o),
        .start_o     (start),
        .src_o       (cfg_src),
        .dst_o       (cfg_dst),
        .len_o       (cfg_len),
        .done_i      (done),
        .busy_o      (busy),
        .win_rd_en_o (win_rd_en),
        .win_wr_en_o (win_wr_en),
        .win_word_o  (win_word),
        .win_wdata_o (win_wdata),
        .win_rdata_i (mem_rd_data)
    );

    dma_addr_gen u_gen (
        .clk        (clk),
        .reset_i    (reset_i),
        .start_i    (start),
        .src_i      (cfg_src),
        .dst_i      (cfg_dst),
        .len_i      (cfg_len),
        .rd_en_o    (gen_rd_en),
        .rd_word_o  (gen_rd_word),
        .src_lane_o (gen_lane),
        .dst_addr_o (gen_dst),
        .last_o     (gen_last)
    );

    // ----------------------------------------------------------------------
    // memory port select, pipeline while busy, apb window while idle
    // ----------------------------------------------------------------------

    assign mem_rd_en   = busy ? gen_rd_en   : win_rd_en;
    assign mem_rd_word = busy ? gen_rd_word : win_word;
    assign mem_wr_en   = busy ? mov_wr_en   : win_wr_en;
    assign mem_wr_word = busy ? mov_wr_word : win_word;
    // window writes are always full words
    assign mem_wr_strb = busy ? mov_wr_strb : '1;
    assign mem_wr_data = busy ? mov_wr_data : win_wdata;

    dma_scratch_mem u_mem (
        .clk       (clk),
        .rd_en_i   (mem_rd_en),
        .rd_word_i (mem_rd_word),
        .rd_data_o (mem_rd_data),
        .wr_en_i   (mem_wr_en),
        .wr_word_i (mem_wr_word),
        .wr_strb_i (mem_wr_strb),
        .wr_data_i (mem_wr_data)
    );

    dma_byte_mover u_mover (
        .clk        (clk),
        .reset_i    (reset_i),
        .valid_i    (gen_rd_en),
        .src_lane_i (gen_lane),
        .dst_addr_i (gen_dst),
        .last_i     (gen_last),
        .rd_data_i  (mem_rd_data),
        .wr_en_o    (mov_wr_en),
        .wr_word_o  (mov_wr_word),
        .wr_strb_o  (mov_wr_strb),
        .wr_data_o  (mov_wr_data),
        .done_o     (done)
    );

    assign busy_o = busy;

endmodule
